/* dat_pkg.sv */
// DAT subsystem shared types
package dat_pkg;

    // Table geometry
    localparam int unsigned DatDepth = 16;
    localparam int unsigned DatAw = 4;

    // System clocks per SCL half period
    localparam int unsigned SclHalfPeriod = 4;

    // Host command opcodes
    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,
        OP_ADDR
    } dat_op_e;

    // One Device Address Table entry
    typedef struct packed {
        logic [6:0] static_addr;
        logic [6:0] dyn_addr;
        logic       push_pull;
        logic       reserved;
    } dat_entry_t;

    // Host command
    typedef struct packed {
        dat_op_e          op;
        logic [DatAw-1:0] index;
        logic             rnw;
        dat_entry_t       entry;
    } dat_cmd_t;

    // Host response, nack only meaningful for OP_ADDR
    typedef struct packed {
        dat_op_e    op;
        dat_entry_t entry;
        logic       nack;
    } dat_rsp_t;

    // Table memory request
    typedef struct packed {
        logic             req;
        logic             write;
        logic [DatAw-1:0] addr;
        dat_entry_t       wdata;
    } dat_mem_sink_t;

    // Table memory response
    typedef struct packed {
        dat_entry_t rdata;
    } dat_mem_src_t;

    // Serializer request and result
    typedef struct packed {
        logic [6:0] dyn_addr;
        logic       rnw;
        logic       push_pull;
    } xfer_req_t;

    typedef struct packed {
        logic nack;
    } xfer_status_t;

endpackage

/* dat_ram.sv */
// DAT table memory
`timescale 1ns/1ps

module dat_ram (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  dat_pkg::dat_mem_sink_t mem_sink_i,
    output dat_pkg::dat_mem_src_t  mem_src_o
);
    import dat_pkg::*;

    dat_entry_t mem_q [DatDepth];
    dat_entry_t rdata_q;

    // Array write port
    always_ff @(posedge clk_i) begin
        if (mem_sink_i.req && mem_sink_i.write) begin
            mem_q[mem_sink_i.addr] <= mem_sink_i.wdata;
        end
    end

    // Read data appears the cycle after the request
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdata_q <= '0;
        end else if (mem_sink_i.req && !mem_sink_i.write) begin
            rdata_q <= mem_q[mem_sink_i.addr];
        end
    end

    assign mem_src_o.rdata = rdata_q;

endmodule

/* dat_cmd_frontend.sv */
// DAT command front end
`timescale 1ns/1ps

module dat_cmd_frontend (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  dat_pkg::dat_cmd_t      cmd_i,
    input  logic                   cmd_valid_i,
    output logic                   cmd_ready_o,
    output dat_pkg::dat_rsp_t      rsp_o,
    output logic                   rsp_valid_o,
    input  logic                   rsp_ready_i,
    output dat_pkg::dat_mem_sink_t mem_sink_o,
    input  dat_pkg::dat_mem_src_t  mem_src_i,
    output dat_pkg::xfer_req_t     xfer_o,
    output logic                   xfer_valid_o,
    input  logic                   xfer_ready_i,
    input  dat_pkg::xfer_status_t  status_i,
    input  logic                   status_valid_i,
    output logic                   status_ready_o
);
    import dat_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_WAIT,
        S_XFER_REQ,
        S_XFER_WAIT,
        S_RSP
    } fe_state_e;

    fe_state_e  state_q;
    dat_op_e    op_q;
    logic       rnw_q;
    logic       nack_q;
    dat_entry_t entry_q;
    logic       cmd_take;

    // New commands only start from idle
    assign cmd_ready_o = (state_q == S_IDLE);
    assign cmd_take    = cmd_ready_o && cmd_valid_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE: begin
                    // Writes finish in the accept cycle
                    if (cmd_take && cmd_i.op != OP_WRITE) begin
                        state_q <= S_RD_WAIT;
                    end
                end
                S_RD_WAIT: state_q <= (op_q == OP_ADDR) ? S_XFER_REQ : S_RSP;
                S_XFER_REQ: begin
                    if (xfer_ready_i) begin
                        state_q <= S_XFER_WAIT;
                    end
                end
                S_XFER_WAIT: begin
                    if (status_valid_i) begin
                        state_q <= S_RSP;
                    end
                end
                S_RSP: begin
                    if (rsp_ready_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Command fields, read entry and bus result
    always_ff @(posedge clk_i) begin
        if (cmd_take) begin
            op_q   <= cmd_i.op;
            rnw_q  <= cmd_i.rnw;
            nack_q <= 1'b0;
        end
        if (state_q == S_RD_WAIT) begin
            entry_q <= mem_src_i.rdata;
        end
        if (state_q == S_XFER_WAIT && status_valid_i) begin
            nack_q <= status_i.nack;
        end
    end

    // Memory port is driven straight from the accepted command
    assign mem_sink_o.req   = cmd_take;
    assign mem_sink_o.write = (cmd_i.op == OP_WRITE);
    assign mem_sink_o.addr  = cmd_i.index;
    assign mem_sink_o.wdata = cmd_i.entry;

    assign xfer_o.dyn_addr  = entry_q.dyn_addr;
    assign xfer_o.rnw       = rnw_q;
    assign xfer_o.push_pull = entry_q.push_pull;
    assign xfer_valid_o     = (state_q == S_XFER_REQ);
    assign status_ready_o   = (state_q == S_XFER_WAIT);

    assign rsp_o.op    = op_q;
    assign rsp_o.entry = entry_q;
    assign rsp_o.nack  = nack_q;
    assign rsp_valid_o = (state_q == S_RSP);

endmodule

/* addr_serializer.sv */
// I3C address phase serializer
`timescale 1ns/1ps

module addr_serializer (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  dat_pkg::xfer_req_t    xfer_i,
    input  logic                  xfer_valid_i,
    output logic                  xfer_ready_o,
    output dat_pkg::xfer_status_t status_o,
    output logic                  status_valid_o,
    input  logic                  status_ready_i,
    input  logic                  sda_i,
    output logic                  scl_o,
    output logic                  sda_o,
    output logic                  sel_od_pp_o
);
    import dat_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_BIT_LOW,
        S_BIT_HIGH,
        S_STOP_LOW,
        S_STOP_HIGH,
        S_DONE
    } ser_state_e;

    typedef logic [$clog2(SclHalfPeriod)-1:0] half_cnt_t;

    ser_state_e state_q;
    half_cnt_t  half_cnt_q;
    logic [3:0] bit_cnt_q;
    logic [8:0] shift_q;
    logic       pp_q;
    logic       scl_q;
    logic       sda_q;
    logic       sel_q;
    logic       nack_q;
    logic       half_last;
    logic       half_mid;
    logic       ack_slot;

    assign half_last = (half_cnt_q == half_cnt_t'(SclHalfPeriod - 1));
    assign half_mid  = (half_cnt_q == half_cnt_t'(SclHalfPeriod / 2));
    // Ninth bit is the ACK slot
    assign ack_slot  = (bit_cnt_q == 4'd8);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= S_IDLE;
            half_cnt_q <= '0;
            bit_cnt_q  <= '0;
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
            sel_q      <= 1'b0;
            nack_q     <= 1'b0;
        end else begin
            if (state_q == S_IDLE || state_q == S_DONE || half_last) begin
                half_cnt_q <= '0;
            end else begin
                half_cnt_q <= half_cnt_q + 1'b1;
            end
            case (state_q)
                S_IDLE: begin
                    if (xfer_valid_i) begin
                        // START: SDA falls with SCL high
                        state_q   <= S_START;
                        bit_cnt_q <= '0;
                        sda_q     <= 1'b0;
                    end
                end
                S_START: begin
                    if (half_last) begin
                        state_q <= S_BIT_LOW;
                        scl_q   <= 1'b0;
                    end
                end
                S_BIT_LOW: begin
                    // SDA moves one clock after SCL falls
                    if (half_cnt_q == '0) begin
                        sda_q <= shift_q[8];
                        sel_q <= pp_q && !ack_slot;
                    end
                    if (half_last) begin
                        state_q <= S_BIT_HIGH;
                        scl_q   <= 1'b1;
                    end
                end
                S_BIT_HIGH: begin
                    if (ack_slot && half_mid) begin
                        nack_q <= sda_i;
                    end
                    if (half_last) begin
                        scl_q <= 1'b0;
                        if (ack_slot) begin
                            state_q <= S_STOP_LOW;
                        end else begin
                            state_q   <= S_BIT_LOW;
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end
                end
                S_STOP_LOW: begin
                    if (half_cnt_q == '0) begin
                        sda_q <= 1'b0;
                    end
                    if (half_last) begin
                        state_q <= S_STOP_HIGH;
                        scl_q   <= 1'b1;
                    end
                end
                S_STOP_HIGH: begin
                    // STOP: SDA rises with SCL high
                    if (half_mid) begin
                        sda_q <= 1'b1;
                    end
                    if (half_last) begin
                        state_q <= S_DONE;
                    end
                end
                S_DONE: begin
                    if (status_ready_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Address byte then a released ACK bit
    always_ff @(posedge clk_i) begin
        if (state_q == S_IDLE && xfer_valid_i) begin
            shift_q <= {xfer_i.dyn_addr, xfer_i.rnw, 1'b1};
            pp_q    <= xfer_i.push_pull;
        end else if (state_q == S_BIT_HIGH && half_last) begin
            shift_q <= {shift_q[7:0], 1'b0};
        end
    end

    assign xfer_ready_o   = (state_q == S_IDLE);
    assign status_valid_o = (state_q == S_DONE);
    assign status_o.nack  = nack_q;
    assign scl_o          = scl_q;
    assign sda_o          = sda_q;
    assign sel_od_pp_o    = sel_q;

endmodule

/* dat_wrapper.sv */
// DAT subsystem top level
`timescale 1ns/1ps

module dat_wrapper (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  dat_pkg::dat_cmd_t cmd_i,
    input  logic              cmd_valid_i,
    output logic              cmd_ready_o,
    output dat_pkg::dat_rsp_t rsp_o,
    output logic              rsp_valid_o,
    input  logic              rsp_ready_i,

    // I3C pads
    // scl_i is unused here, the core always drives SCL push-pull
    input  logic              scl_i,
    input  logic              sda_i,
    output logic              scl_o,
    output logic              sda_o,
    output logic              sda_oe_o,
    output logic              sel_od_pp_o
);
    import dat_pkg::*;

    dat_mem_sink_t dat_mem_sink;
    dat_mem_src_t  dat_mem_src;
    xfer_req_t     xfer;
    logic          xfer_valid;
    logic          xfer_ready;
    xfer_status_t  status;
    logic          status_valid;
    logic          status_ready;

    dat_cmd_frontend cmd_frontend (
        .clk_i,
        .arst_n_i,
        .cmd_i,
        .cmd_valid_i,
        .cmd_ready_o,
        .rsp_o,
        .rsp_valid_o,
        .rsp_ready_i,
        .mem_sink_o    (dat_mem_sink),
        .mem_src_i     (dat_mem_src),
        .xfer_o        (xfer),
        .xfer_valid_o  (xfer_valid),
        .xfer_ready_i  (xfer_ready),
        .status_i      (status),
        .status_valid_i(status_valid),
        .status_ready_o(status_ready)
    );

    dat_ram dat_memory (
        .clk_i,
        .arst_n_i,
        .mem_sink_i(dat_mem_sink),
        .mem_src_o (dat_mem_src)
    );

    addr_serializer addr_ser (
        .clk_i,
        .arst_n_i,
        .xfer_i        (xfer),
        .xfer_valid_i  (xfer_valid),
        .xfer_ready_o  (xfer_ready),
        .status_o      (status),
        .status_valid_o(status_valid),
        .status_ready_i(status_ready),
        .sda_i,
        .scl_o,
        .sda_o,
        .sel_od_pp_o
    );

    // Drive SDA in push-pull mode, otherwise only pull it low
    assign sda_oe_o = sel_od_pp_o || !sda_o;

endmodule

/* tb_checks.svh */
// Testbench compare tasks
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int err_cnt = 0;
int tests_passed = 0;
int tests_failed = 0;

task automatic check_entry(input string name, input dat_entry_t exp, input dat_entry_t act);
    if (act !== exp) begin
        err_cnt++;
        $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
    end
endtask

task automatic check_rsp(input string name, input dat_rsp_t exp, input dat_rsp_t act);
    if (act !== exp) begin
        err_cnt++;
        $display("FAIL %0t %s expected op=%0d entry=%h nack=%b got op=%0d entry=%h nack=%b",
                 $time, name, exp.op, exp.entry, exp.nack, act.op, act.entry, act.nack);
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        err_cnt++;
        $display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
    end
endtask

// Address byte seen by the bus target
task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
        err_cnt++;
        $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
    end
endtask

task automatic report_test(input string name, input int errs);
    if (errs == 0) begin
        tests_passed++;
        $display("Test %s: passed", name);
    end else begin
        tests_failed++;
        $display("Test %s: failed with %0d errors", name, errs);
    end
endtask

`endif

/* tb_dat_wrapper.sv */
// DAT wrapper testbench
`timescale 1ns/1ps

module tb_dat_wrapper;
    import dat_pkg::*;

    localparam int ClkPeriod = 40;
    localparam int ResetCycles = 16;
    localparam int TimeoutCycles = 3000;
    localparam logic [31:0] Seed = 32'd33826;
    localparam logic [6:0] TargetAddr = 7'h2a;

    logic       clk_i;
    logic       arst_n_i;
    dat_cmd_t   cmd_i;
    logic       cmd_valid_i;
    logic       cmd_ready_o;
    dat_rsp_t   rsp_o;
    logic       rsp_valid_o;
    logic       rsp_ready_i;
    logic       scl_o;
    logic       sda_o;
    logic       sda_oe_o;
    logic       sel_od_pp_o;
    wire        sda_line;

    // Bus target model
    logic       tgt_ack = 1'b0;
    logic       in_frame = 1'b0;
    logic       rx_done = 1'b0;
    logic       tgt_matched = 1'b0;
    logic [7:0] rx_byte = '0;
    int         rx_cnt = 0;

    logic        pp_expected = 1'b0;
    logic [31:0] rng_state = Seed;
    dat_entry_t  table_model [DatDepth];
    int          cycle_cnt = 0;
    int          pad_before;
    int          pad_errs = 0;

    `include "tb_checks.svh"

    // Open-drain line with pull-up and the target's ACK pull-down
    assign sda_line = (sda_oe_o ? sda_o : 1'b1) && !tgt_ack;

    dat_wrapper UUT (
        .clk_i,
        .arst_n_i,
        .cmd_i,
        .cmd_valid_i,
        .cmd_ready_o,
        .rsp_o,
        .rsp_valid_o,
        .rsp_ready_i,
        .scl_i      (scl_o),
        .sda_i      (sda_line),
        .scl_o,
        .sda_o,
        .sda_oe_o,
        .sel_od_pp_o
    );

    initial begin
        clk_i = 1'b0;
        forever #(ClkPeriod / 2) clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TimeoutCycles) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // START is SDA falling while SCL is high
    always @(negedge sda_line) begin
        if (scl_o === 1'b1) begin
            in_frame = 1'b1;
            rx_cnt   = 0;
            rx_done  = 1'b0;
        end
    end

    always @(posedge scl_o) begin
        if (in_frame) begin
            if (rx_cnt < 8) begin
                // Push-pull drive follows the entry during address bits
                check_bit("sel_od_pp_o", pp_expected, sel_od_pp_o);
                rx_byte = {rx_byte[6:0], sda_line};
                rx_cnt++;
                rx_done = (rx_cnt == 8);
            end else begin
                // Ninth rise is the ACK slot
                in_frame = 1'b0;
            end
        end
    end

    // Pull SDA low for the ACK slot on an address match
    always @(negedge scl_o) begin
        if (in_frame && rx_cnt == 8 && rx_byte[7:1] == TargetAddr) begin
            tgt_ack     = 1'b1;
            tgt_matched = 1'b1;
        end else begin
            tgt_ack = 1'b0;
        end
    end

    // Pad rule checked every cycle
    always @(negedge clk_i) begin
        if (arst_n_i) begin
            pad_before = err_cnt;
            check_bit("sda_oe_o", sel_od_pp_o || !sda_o, sda_oe_o);
            if (!(pp_expected && in_frame)) begin
                check_bit("sel_od_pp_o", 1'b0, sel_od_pp_o);
            end
            pad_errs += err_cnt - pad_before;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // Called and returns on a falling edge
    task automatic send_cmd(input dat_op_e op, input logic [DatAw-1:0] index,
                            input logic rnw, input dat_entry_t entry);
        while (cmd_ready_o !== 1'b1) begin
            @(negedge clk_i);
        end
        cmd_i.op    = op;
        cmd_i.index = index;
        cmd_i.rnw   = rnw;
        cmd_i.entry = entry;
        cmd_valid_i = 1'b1;
        @(negedge clk_i);
        cmd_valid_i = 1'b0;
    endtask

    task automatic wait_rsp(output dat_rsp_t r);
        while (rsp_valid_o !== 1'b1) begin
            @(negedge clk_i);
        end
        r = rsp_o;
        @(negedge clk_i);
    endtask

    task automatic test_reset();
        int errs;
        errs = err_cnt;
        check_bit("cmd_ready_o", 1'b1, cmd_ready_o);
        check_bit("rsp_valid_o", 1'b0, rsp_valid_o);
        check_bit("scl_o", 1'b1, scl_o);
        check_bit("sda_o", 1'b1, sda_o);
        check_bit("sel_od_pp_o", 1'b0, sel_od_pp_o);
        check_bit("sda_oe_o", 1'b0, sda_oe_o);
        report_test("reset state", err_cnt - errs);
    endtask

    task automatic test_write_read();
        int          errs;
        int          i;
        int          idx;
        logic [31:0] rnd;
        dat_rsp_t    r;
        dat_rsp_t    exp;
        errs = err_cnt;
        for (i = 0; i < DatDepth; i++) begin
            rnd = next_rand();
            table_model[i] = rnd[15:0];
            send_cmd(OP_WRITE, i[DatAw-1:0], 1'b0, table_model[i]);
            check_bit("cmd_ready_o", 1'b1, cmd_ready_o);
        end
        // Stride 7 visits every index in a new order
        for (i = 0; i < DatDepth; i++) begin
            idx = (i * 7 + 3) % DatDepth;
            send_cmd(OP_READ, idx[DatAw-1:0], 1'b0, '0);
            wait_rsp(r);
            exp.op    = OP_READ;
            exp.entry = table_model[idx];
            exp.nack  = 1'b0;
            check_rsp("rsp_o", exp, r);
        end
        report_test("write and read back", err_cnt - errs);
    endtask

    task automatic test_backpressure();
        int       errs;
        dat_rsp_t exp;
        errs = err_cnt;
        rsp_ready_i = 1'b0;
        send_cmd(OP_READ, 4'd5, 1'b0, '0);
        check_bit("rsp_valid_o", 1'b0, rsp_valid_o);
        // Response two cycles after accept
        @(negedge clk_i);
        check_bit("rsp_valid_o", 1'b1, rsp_valid_o);
        exp.op    = OP_READ;
        exp.entry = table_model[5];
        exp.nack  = 1'b0;
        repeat (6) begin
            check_rsp("rsp_o", exp, rsp_o);
            check_entry("rsp_o.entry", table_model[5], rsp_o.entry);
            check_bit("cmd_ready_o", 1'b0, cmd_ready_o);
            @(negedge clk_i);
            check_bit("rsp_valid_o", 1'b1, rsp_valid_o);
        end
        rsp_ready_i = 1'b1;
        @(negedge clk_i);
        check_bit("rsp_valid_o", 1'b0, rsp_valid_o);
        check_bit("cmd_ready_o", 1'b1, cmd_ready_o);
        report_test("back-pressure", err_cnt - errs);
    endtask

    task automatic test_address(input string name, input logic [DatAw-1:0] index,
                                input logic [6:0] dyn_addr, input logic push_pull,
                                input logic rnw);
        int          errs;
        logic [31:0] rnd;
        dat_entry_t  e;
        dat_rsp_t    r;
        dat_rsp_t    exp;
        errs = err_cnt;
        rnd = next_rand();
        e = rnd[15:0];
        e.dyn_addr  = dyn_addr;
        e.push_pull = push_pull;
        table_model[index] = e;
        send_cmd(OP_WRITE, index, 1'b0, e);
        tgt_matched = 1'b0;
        rx_done     = 1'b0;
        rx_byte     = '0;
        pp_expected = push_pull;
        send_cmd(OP_ADDR, index, rnw, '0);
        wait_rsp(r);
        pp_expected = 1'b0;
        exp.op    = OP_ADDR;
        exp.entry = e;
        exp.nack  = (dyn_addr != TargetAddr);
        check_rsp("rsp_o", exp, r);
        check_bit("target frame complete", 1'b1, rx_done);
        check_byte("target rx byte", {dyn_addr, rnw}, rx_byte);
        check_bit("target matched", dyn_addr == TargetAddr, tgt_matched);
        report_test(name, err_cnt - errs);
    endtask

    initial begin
        arst_n_i    = 1'b0;
        cmd_i       = '0;
        cmd_valid_i = 1'b0;
        rsp_ready_i = 1'b1;
        repeat (ResetCycles) @(negedge clk_i);
        arst_n_i = 1'b1;

        test_reset();
        test_write_read();
        test_backpressure();
        test_address("address ack push-pull", 4'd3, TargetAddr, 1'b1, 1'b1);
        test_address("address ack open-drain", 4'd9, TargetAddr, 1'b0, 1'b0);
        test_address("address nack", 4'd12, TargetAddr ^ 7'h15, 1'b1, 1'b0);
        report_test("pad rule", pad_errs);

        $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0 && err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+.
dat_pkg.sv
dat_ram.sv
dat_cmd_frontend.sv
addr_serializer.sv
dat_wrapper.sv
tb_dat_wrapper.sv
